//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = tbGteRegisterUnit
FILELIST  = gteRegs.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

# Build, run, then decide pass or fail from the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "sim passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- common/gtePkg.sv
package gtePkg;

	// ----------------------------
	// Widths
	// ----------------------------
	localparam int REG_ID_W    = 6;	// 64 CPU visible registers
	localparam int WORD_W      = 32;
	localparam int BANK_ADDR_W = 5;	// Index bit above this one picks the bank

	// ----------------------------
	// Data registers 0..31
	// ----------------------------
	localparam logic [REG_ID_W-1:0] VZ0  = 6'd1;
	localparam logic [REG_ID_W-1:0] VZ1  = 6'd3;
	localparam logic [REG_ID_W-1:0] VZ2  = 6'd5;
	localparam logic [REG_ID_W-1:0] RGBC = 6'd6;	// Code byte lives in bits 31:24
	localparam logic [REG_ID_W-1:0] OTZ  = 6'd7;
	localparam logic [REG_ID_W-1:0] IR0  = 6'd8;
	localparam logic [REG_ID_W-1:0] IR1  = 6'd9;
	localparam logic [REG_ID_W-1:0] IR2  = 6'd10;
	localparam logic [REG_ID_W-1:0] IR3  = 6'd11;
	localparam logic [REG_ID_W-1:0] SXY0 = 6'd12;
	localparam logic [REG_ID_W-1:0] SXY1 = 6'd13;
	localparam logic [REG_ID_W-1:0] SXY2 = 6'd14;
	localparam logic [REG_ID_W-1:0] SXYP = 6'd15;	// Push port, reads as SXY2
	localparam logic [REG_ID_W-1:0] SZ0  = 6'd16;
	localparam logic [REG_ID_W-1:0] SZ1  = 6'd17;
	localparam logic [REG_ID_W-1:0] SZ2  = 6'd18;
	localparam logic [REG_ID_W-1:0] SZ3  = 6'd19;
	localparam logic [REG_ID_W-1:0] RGB0 = 6'd20;
	localparam logic [REG_ID_W-1:0] RGB1 = 6'd21;
	localparam logic [REG_ID_W-1:0] RGB2 = 6'd22;
	localparam logic [REG_ID_W-1:0] IRGB = 6'd28;
	localparam logic [REG_ID_W-1:0] ORGB = 6'd29;	// Read only view of IR1..IR3
	localparam logic [REG_ID_W-1:0] LZCS = 6'd30;
	localparam logic [REG_ID_W-1:0] LZCR = 6'd31;

	// ----------------------------
	// Control registers 32..63
	// ----------------------------
	localparam logic [REG_ID_W-1:0] R33  = 6'd36;
	localparam logic [REG_ID_W-1:0] L33  = 6'd44;
	localparam logic [REG_ID_W-1:0] LB3  = 6'd52;
	localparam logic [REG_ID_W-1:0] H    = 6'd58;	// First of the zero filled block
	localparam logic [REG_ID_W-1:0] ZSF4 = 6'd62;	// Last of the zero filled block
	localparam logic [REG_ID_W-1:0] FLAG = 6'd63;	// Plain storage here

	// Two 16 bit halves, SX in low and SY in high
	typedef struct packed {
		logic [15:0] hi;
		logic [15:0] lo;
	} gteHalves_t;

	// One register word, seen whole, as halves or as bytes
	typedef union packed {
		logic [WORD_W-1:0] word;
		gteHalves_t        halves;
		logic [3:0][7:0]   bytes;	// [0] R, [1] G, [2] B, [3] code
	} gteWord_u;

endpackage

//--- gte/gteRegisterUnit.sv
`timescale 1ns/1ps

module gteRegisterUnit (
	input  logic                        i_clk,
	input  logic                        i_arstN,
	input  logic [gtePkg::REG_ID_W-1:0] i_regId,
	input  logic                        i_writeReg,	// One cycle per write
	input  logic                        i_readReg,	// One cycle per read
	input  logic [gtePkg::WORD_W-1:0]   i_dataIn,
	output logic [gtePkg::WORD_W-1:0]   o_dataOut	// Valid one cycle after the read
);

	import gtePkg::*;

	logic [WORD_W-1:0] dataWord;
	logic [WORD_W-1:0] ctrlWord;
	logic [15:0]       ir0, ir1, ir2, ir3;
	logic [15:0]       sz0, sz1, sz2, sz3;
	gteWord_u          sxy0, sxy1, sxy2;
	gteWord_u          crgb0, crgb1, crgb2;
	logic [5:0]        lzcr;
	logic [7:0]        code;

	// ----------------------------
	// Register banks
	// ----------------------------
	gteRegBank #(.BANK(1'b0)) gteDataBank_inst (	// Indices 0..31
		.i_clk      (i_clk),
		.i_arstN    (i_arstN),
		.i_regId    (i_regId),
		.i_writeReg (i_writeReg),
		.i_readReg  (i_readReg),
		.i_dataIn   (i_dataIn),
		.o_rdata    (dataWord)
	);

	gteRegBank #(.BANK(1'b1)) gteCtrlBank_inst (	// Indices 32..63
		.i_clk      (i_clk),
		.i_arstN    (i_arstN),
		.i_regId    (i_regId),
		.i_writeReg (i_writeReg),
		.i_readReg  (i_readReg),
		.i_dataIn   (i_dataIn),
		.o_rdata    (ctrlWord)
	);

	// Registers held outside the banks
	gteSpecialRegs gteSpecialRegs_inst (
		.i_clk      (i_clk),
		.i_arstN    (i_arstN),
		.i_regId    (i_regId),
		.i_writeReg (i_writeReg),
		.i_dataIn   (i_dataIn),
		.o_ir1      (ir1),
		.o_ir2      (ir2),
		.o_ir3      (ir3),
		.o_sxy0     (sxy0),
		.o_sxy1     (sxy1),
		.o_sxy2     (sxy2),
		.o_sz0      (sz0),
		.o_sz1      (sz1),
		.o_sz2      (sz2),
		.o_sz3      (sz3),
		.o_crgb0    (crgb0),
		.o_crgb1    (crgb1),
		.o_crgb2    (crgb2),
		.o_ir0      (ir0),
		.o_lzcr     (lzcr),
		.o_code     (code)
	);

	// ----------------------------
	// CPU read path
	// ----------------------------
	gteReadMux gteReadMux_inst (
		.i_clk      (i_clk),
		.i_arstN    (i_arstN),
		.i_regId    (i_regId),
		.i_readReg  (i_readReg),
		.i_dataWord (dataWord),
		.i_ctrlWord (ctrlWord),
		.i_ir1      (ir1),
		.i_ir2      (ir2),
		.i_ir3      (ir3),
		.i_sxy0     (sxy0),
		.i_sxy1     (sxy1),
		.i_sxy2     (sxy2),
		.i_sz0      (sz0),
		.i_sz1      (sz1),
		.i_sz2      (sz2),
		.i_sz3      (sz3),
		.i_crgb0    (crgb0),
		.i_crgb1    (crgb1),
		.i_crgb2    (crgb2),
		.i_ir0      (ir0),
		.i_lzcr     (lzcr),
		.i_code     (code),
		.o_dataOut  (o_dataOut)
	);

endmodule

//--- gteRegs.f
common/gtePkg.sv
regfile/gteRegBank.sv
logic/gteLeadCount.sv
special/gteSpecialRegs.sv
logic/gteReadMux.sv
gte/gteRegisterUnit.sv
sim/tbGteRegisterUnit.sv

//--- logic/gteLeadCount.sv
`timescale 1ns/1ps

module gteLeadCount (
	input  logic [31:0] i_value,
	output logic [5:0]  o_count
);

	// Bits that differ from the sign bit
	logic [30:0] diff;

	assign diff = i_value[30:0] ^ {31{i_value[31]}};

	// Leading zero count of diff, plus the sign bit itself
	always_comb begin
		o_count = 6'd32;	// Every bit equals the sign
		for (int i = 0; i < 31; i++) begin
			if (diff[i]) begin
				o_count = 6'(31 - i);	// Highest differing bit wins
			end
		end
	end

endmodule

//--- logic/gteReadMux.sv
`timescale 1ns/1ps

module gteReadMux (
	input  logic                        i_clk,
	input  logic                        i_arstN,
	input  logic [gtePkg::REG_ID_W-1:0] i_regId,
	input  logic                        i_readReg,
	input  logic [31:0]                 i_dataWord,	// Registered data bank word
	input  logic [31:0]                 i_ctrlWord,	// Registered control bank word

	input  logic [15:0]                 i_ir1,
	input  logic [15:0]                 i_ir2,
	input  logic [15:0]                 i_ir3,
	input  gtePkg::gteWord_u            i_sxy0,
	input  gtePkg::gteWord_u            i_sxy1,
	input  gtePkg::gteWord_u            i_sxy2,
	input  logic [15:0]                 i_sz0,
	input  logic [15:0]                 i_sz1,
	input  logic [15:0]                 i_sz2,
	input  logic [15:0]                 i_sz3,
	input  gtePkg::gteWord_u            i_crgb0,
	input  gtePkg::gteWord_u            i_crgb1,
	input  gtePkg::gteWord_u            i_crgb2,
	input  logic [15:0]                 i_ir0,
	input  logic [5:0]                  i_lzcr,
	input  logic [7:0]                  i_code,

	output logic [gtePkg::WORD_W-1:0]   o_dataOut
);

	import gtePkg::*;

	logic [REG_ID_W-1:0] rdIdx;	// Index of the last read
	logic                rdSignExt;
	logic                rdZeroFill;
	logic                signClass;
	logic                zeroClass;
	logic [14:0]         orgb;
	gteWord_u            srcWord;

	// Saturate one IR to a 5 bit colour channel
	function automatic logic [4:0] orgbChannel(input logic [15:0] ir);
		if (ir[15]) begin
			return 5'd0;	// Negative
		end else if (|ir[14:12]) begin
			return 5'd31;	// Over range
		end else begin
			return ir[11:7];
		end
	endfunction

	// ----------------------------
	// Widening class of the live index
	// ----------------------------
	assign signClass = (i_regId == R33) || (i_regId == L33) || (i_regId == LB3)
		|| (i_regId == VZ0) || (i_regId == VZ1) || (i_regId == VZ2)
		|| ((i_regId >= IR0) && (i_regId <= IR3));

	assign zeroClass = ((i_regId >= H) && (i_regId <= ZSF4))
		|| ((i_regId >= SZ0) && (i_regId <= SZ3))
		|| (i_regId == OTZ);

	always_ff @(posedge i_clk or negedge i_arstN) begin
		if (!i_arstN) begin
			rdIdx      <= '0;
			rdSignExt  <= 1'b0;
			rdZeroFill <= 1'b0;
		end else if (i_readReg) begin
			rdIdx      <= i_regId;
			rdSignExt  <= signClass;
			rdZeroFill <= zeroClass;
		end
	end

	// Blue in the high bits and red in the low bits
	assign orgb = {orgbChannel(i_ir3), orgbChannel(i_ir2), orgbChannel(i_ir1)};

	// ----------------------------
	// Source select
	// ----------------------------
	always_comb begin
		srcWord.word = i_dataWord;	// Plain data register
		if (rdIdx[BANK_ADDR_W]) begin
			srcWord.word = i_ctrlWord;
		end else begin
			case (rdIdx)
				IR0:        srcWord.word = {16'h0000, i_ir0};
				IR1:        srcWord.word = {16'h0000, i_ir1};
				IR2:        srcWord.word = {16'h0000, i_ir2};
				IR3:        srcWord.word = {16'h0000, i_ir3};
				SXY0:       srcWord = i_sxy0;
				SXY1:       srcWord = i_sxy1;
				SXY2, SXYP: srcWord = i_sxy2;	// SXYP mirrors the FIFO tail
				SZ0:        srcWord.word = {16'h0000, i_sz0};
				SZ1:        srcWord.word = {16'h0000, i_sz1};
				SZ2:        srcWord.word = {16'h0000, i_sz2};
				SZ3:        srcWord.word = {16'h0000, i_sz3};
				RGB0:       srcWord = i_crgb0;
				RGB1:       srcWord = i_crgb1;
				RGB2:       srcWord = i_crgb2;
				IRGB, ORGB: srcWord.word = {17'd0, orgb};
				LZCR:       srcWord.word = {26'd0, i_lzcr};
				default: ;
			endcase
		end
	end

	// ----------------------------
	// Widening of the upper half
	// ----------------------------
	always_comb begin
		if (rdSignExt) begin
			o_dataOut = {{16{srcWord.halves.lo[15]}}, srcWord.halves.lo};
		end else if (rdZeroFill) begin
			o_dataOut = {16'h0000, srcWord.halves.lo};
		end else begin
			o_dataOut = srcWord.word;	// Full 32 bits
		end
	end

endmodule

//--- regfile/gteRegBank.sv
`timescale 1ns/1ps

module gteRegBank #(
	parameter bit BANK = 1'b0	// Value of i_regId[5] served here
) (
	input  logic        i_clk,
	input  logic        i_arstN,
	input  logic [5:0]  i_regId,
	input  logic        i_writeReg,
	input  logic        i_readReg,
	input  logic [31:0] i_dataIn,
	output logic [31:0] o_rdata
);

	logic [31:0] mem [0:31];	// 32 words, no reset
	logic        bankHit;

	assign bankHit = (i_regId[5] == BANK);	// Upper index bit selects the bank

	// Write port
	always_ff @(posedge i_clk) begin
		if (i_writeReg && bankHit) begin
			mem[i_regId[4:0]] <= i_dataIn;
		end
	end

	// Registered read, held between reads
	always_ff @(posedge i_clk or negedge i_arstN) begin
		if (!i_arstN) begin
			o_rdata <= '0;
		end else if (i_readReg && bankHit) begin
			o_rdata <= mem[i_regId[4:0]];
		end
	end

endmodule

//--- sim/gteGolden.txt
# op idx data: W writes data to register idx, R reads idx and expects data
# all fields hex, idx 00..3f
R 10 00000000
W 19 a5a51234
R 19 a5a51234
W 3f 8000ffff
R 3f 8000ffff
W 01 12348001
W 24 12348001
W 07 12348001
W 20 12348001
R 01 ffff8001
R 24 ffff8001
R 07 00008001
R 20 12348001
W 0f 00110022
W 0f 00330044
W 0f 00550066
R 0c 00110022
R 0d 00330044
R 0e 00550066
R 0f 00550066
W 0d 7fff8000
R 0c 00110022
R 0d 7fff8000
R 0e 00550066
W 09 00000f80
W 0a 0000ff00
W 0b 00001000
R 1d 00007c1f
R 1c 00007c1f
R 0a ffffff00
W 1e 000000ff
R 1f 00000018
W 1e ffff0000
R 1f 00000010
W 1e 80000000
R 1f 00000001
W 14 3c80ff10
R 14 3c80ff10
W 09 00008000
R 09 ffff8000
W 11 ffff9abc
R 11 00009abc

//--- sim/tbGteRegisterUnit.sv
`timescale 1ns/1ps

module tbGteRegisterUnit;

	localparam int CLK_HALF_NS  = 5;
	localparam int RESET_CYCLES = 16;
	localparam int MAX_RECORDS  = 256;	// Bound on the golden replay
	localparam int SETTLE_LIMIT = 8;	// Cycles allowed for a zero output after reset
	localparam int WATCHDOG_NS  = 200000;

	logic        clk;
	logic        arstN;
	logic [5:0]  regId;
	logic        writeReg;
	logic        readReg;
	logic [31:0] dataIn;
	logic [31:0] dataOut;

	int errors;
	int checks;

	gteRegisterUnit gteRegisterUnit_inst (
		.i_clk      (clk),
		.i_arstN    (arstN),
		.i_regId    (regId),
		.i_writeReg (writeReg),
		.i_readReg  (readReg),
		.i_dataIn   (dataIn),
		.o_dataOut  (dataOut)
	);

	always #CLK_HALF_NS clk = ~clk;	// 10 ns period

	// ------------------------------
	// Helpers
	// ------------------------------
	task automatic compareValue(input string name, input logic [5:0] idx,
		input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %s reg 0x%02h got 0x%08h expected 0x%08h at %0t",
				name, idx, got, exp, $time);
		end
	endtask

	task automatic waitCycles(input int n);
		for (int c = 0; c < n; c++) begin
			@(posedge clk);
		end
	endtask

	// Output must come out of reset as zero
	task automatic waitResetOutput();
		int cycles;
		cycles = 0;
		while (dataOut !== 32'h0 && cycles < SETTLE_LIMIT) begin
			@(negedge clk);
			cycles++;
		end
		if (dataOut !== 32'h0) begin
			errors++;
			$display("read data did not settle to zero after reset");
		end
	endtask

	task automatic writeCycle(input logic [5:0] idx, input logic [31:0] data);
		@(posedge clk);
		regId    <= idx;
		dataIn   <= data;
		writeReg <= 1'b1;
		@(posedge clk);	// Write lands on this edge
		writeReg <= 1'b0;
	endtask

	task automatic readCycle(input logic [5:0] idx, input logic [31:0] exp);
		@(posedge clk);
		regId   <= idx;
		readReg <= 1'b1;
		@(posedge clk);	// Index latched here
		readReg <= 1'b0;
		@(negedge clk);	// Mid idle cycle, output stable
		compareValue("o_dataOut", idx, dataOut, exp);
	endtask

	// Hang guard
	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired before the golden replay finished");
		$display("sim failed");
		$finish;
	end

	// ------------------------------
	// Golden replay
	// ------------------------------
	initial begin
		int          fd;
		int          recs;
		int          nItems;
		bit          fileDone;
		string       line;
		byte         op;
		logic [31:0] idxField;
		logic [31:0] valField;
		clk      = 1'b0;
		errors   = 0;
		checks   = 0;
		recs     = 0;
		fileDone = 1'b0;
		arstN    <= 1'b0;
		regId    <= '0;
		writeReg <= 1'b0;
		readReg  <= 1'b0;
		dataIn   <= '0;

		waitCycles(RESET_CYCLES);
		arstN <= 1'b1;	// Release on a rising edge
		waitResetOutput();

		fd = $fopen("sim/gteGolden.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("could not open the golden file sim/gteGolden.txt");
		end else begin
			while (!fileDone && recs < MAX_RECORDS) begin
				nItems = $fgets(line, fd);
				if (nItems == 0) begin
					fileDone = 1'b1;	// End of file
				end else if (line.len() > 1 && line.getc(0) != "#") begin
					nItems = $sscanf(line, "%c %h %h", op, idxField, valField);
					if (nItems != 3) begin
						errors++;
						$display("malformed golden line: %s", line);
					end else begin
						recs++;
						case (op)
							"W": writeCycle(idxField[5:0], valField);
							"R": readCycle(idxField[5:0], valField);	// Expected value
							default: begin
								errors++;
								$display("unknown record type in golden line: %s", line);
							end
						endcase
					end
				end
			end
			if (!fileDone) begin
				errors++;
				$display("golden file holds more than %0d records", MAX_RECORDS);
			end
			$fclose(fd);
		end
		if (recs == 0) begin
			errors++;
			$display("no records were replayed from the golden file");
		end

		waitCycles(2);
		$display("records %0d checks %0d errors %0d", recs, checks, errors);
		if (errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

//--- special/gteSpecialRegs.sv
`timescale 1ns/1ps

module gteSpecialRegs (
	input  logic                        i_clk,
	input  logic                        i_arstN,
	input  logic [gtePkg::REG_ID_W-1:0] i_regId,
	input  logic                        i_writeReg,
	input  gtePkg::gteWord_u            i_dataIn,

	output logic [15:0]                 o_ir1,
	output logic [15:0]                 o_ir2,
	output logic [15:0]                 o_ir3,
	output gtePkg::gteWord_u            o_sxy0,
	output gtePkg::gteWord_u            o_sxy1,
	output gtePkg::gteWord_u            o_sxy2,
	output logic [15:0]                 o_sz0,
	output logic [15:0]                 o_sz1,
	output logic [15:0]                 o_sz2,
	output logic [15:0]                 o_sz3,
	output gtePkg::gteWord_u            o_crgb0,
	output gtePkg::gteWord_u            o_crgb1,
	output gtePkg::gteWord_u            o_crgb2,
	output logic [15:0]                 o_ir0,
	output logic [5:0]                  o_lzcr,
	output logic [7:0]                  o_code	// Cached RGBC code byte
);

	import gtePkg::*;

	logic [5:0] leadCount;	// Lead count of the word on the bus

	// ----------------------------
	// LZCS lead bit counter
	// ----------------------------
	gteLeadCount gteLeadCount_inst (
		.i_value (i_dataIn.word),
		.o_count (leadCount)
	);

	// ----------------------------
	// CPU write decode
	// ----------------------------
	always_ff @(posedge i_clk or negedge i_arstN) begin
		if (!i_arstN) begin
			o_ir0   <= '0;
			o_ir1   <= '0;
			o_ir2   <= '0;
			o_ir3   <= '0;
			o_sxy0  <= '0;
			o_sxy1  <= '0;
			o_sxy2  <= '0;
			o_sz0   <= '0;
			o_sz1   <= '0;
			o_sz2   <= '0;
			o_sz3   <= '0;
			o_crgb0 <= '0;
			o_crgb1 <= '0;
			o_crgb2 <= '0;
			o_code  <= '0;
			o_lzcr  <= '0;
		end else if (i_writeReg) begin
			case (i_regId)
				// Screen XY, direct or pushed
				SXY0: o_sxy0 <= i_dataIn;
				SXY1: o_sxy1 <= i_dataIn;
				SXY2: o_sxy2 <= i_dataIn;
				SXYP: begin	// Shift toward SXY0, new entry at the tail
					o_sxy0 <= o_sxy1;
					o_sxy1 <= o_sxy2;
					o_sxy2 <= i_dataIn;
				end
				// Depth, low half only
				SZ0:  o_sz0 <= i_dataIn.halves.lo;
				SZ1:  o_sz1 <= i_dataIn.halves.lo;
				SZ2:  o_sz2 <= i_dataIn.halves.lo;
				SZ3:  o_sz3 <= i_dataIn.halves.lo;
				// Interpolation registers
				IR0:  o_ir0 <= i_dataIn.halves.lo;
				IR1:  o_ir1 <= i_dataIn.halves.lo;
				IR2:  o_ir2 <= i_dataIn.halves.lo;
				IR3:  o_ir3 <= i_dataIn.halves.lo;
				// Colour FIFO entries, CPU writes are direct
				RGB0: o_crgb0 <= i_dataIn;
				RGB1: o_crgb1 <= i_dataIn;
				RGB2: o_crgb2 <= i_dataIn;
				RGBC: o_code  <= i_dataIn.bytes[3];	// Keep only the code byte
				LZCS: o_lzcr  <= leadCount;	// Result ready on the next read
				default: ;	// Bank only registers
			endcase
		end
	end

endmodule
